/* flist.f */
+incdir+sim
hdl/rv_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute.sv
hdl/pc_unit.sv
hdl/rv_core.sv
sim/tb_core.sv

/* Makefile */
# build and run the core testbench with verilator

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_core -f flist.f
	./obj_dir/Vtb_core | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* sim/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected outcome of one instruction
typedef struct packed {
  rv_pkg::word_t     next_pc;
  logic              st;
  logic [ADDR_W-1:0] st_addr;
  rv_pkg::word_t     st_data;
} ref_out_t;

// architectural state of the model, x0 never written
rv_pkg::word_t ref_regs [32];
rv_pkg::word_t ref_ram [DEPTH];
rv_pkg::word_t ref_pc;
logic [31:0]   lfsr_state = 32'd71493;

// fibonacci lfsr, taps 32 22 2 1
function automatic rv_pkg::word_t rand_bits(input int n);
  rv_pkg::word_t v;
  logic          fb;
  v = '0;
  for (int k = 0; k < n; k++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v          = {v[30:0], fb};
  end
  return v;
endfunction

// instruction encoders
function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
endfunction

function automatic rv_pkg::word_t enc_i(input rv_pkg::opcode_e op, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
endfunction

// off is the byte offset, bit 0 dropped
function automatic rv_pkg::word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
endfunction

function automatic rv_pkg::word_t enc_u(input rv_pkg::opcode_e op, input logic [19:0] imm,
                                        input logic [4:0] rd);
  return {imm, rd, op};
endfunction

// integer op by funct3, alt picks sub or arithmetic shift
function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv_pkg::word_t a, input rv_pkg::word_t b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    // signed less, sign bits decide when they differ
    3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// one instruction on the model state
function automatic ref_out_t ref_step(input rv_pkg::word_t word);
  rv_pkg::instr_u ins;
  ref_out_t       o;
  rv_pkg::word_t  a;
  rv_pkg::word_t  b;
  rv_pkg::word_t  imm_i;
  rv_pkg::word_t  addr;
  rv_pkg::word_t  res;
  logic           wr;
  ins       = word;
  a         = ref_regs[ins.r.rs1];
  b         = ref_regs[ins.r.rs2];
  imm_i     = {{20{word[31]}}, word[31:20]};
  o         = '0;
  res       = '0;
  wr        = 1'b0;
  o.next_pc = ref_pc + 32'd4;
  case (word[6:0])
    rv_pkg::OP_REG: begin
      wr  = 1'b1;
      res = alu_ref(word[14:12], word[30], a, b);
    end
    rv_pkg::OP_IMM: begin
      wr  = 1'b1;
      // bit 30 is immediate data except on right shifts
      res = alu_ref(word[14:12], word[30] && word[14:12] == 3'b101, a, imm_i);
    end
    rv_pkg::OP_LOAD: begin
      addr = a + imm_i;
      wr   = (word[14:12] == 3'b010);
      res  = ref_ram[addr[ADDR_W+1:2]];
    end
    rv_pkg::OP_STORE: begin
      addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
      if (word[14:12] == 3'b010) begin
        o.st      = 1'b1;
        o.st_addr = addr[ADDR_W+1:2];
        o.st_data = b;
        ref_ram[addr[ADDR_W+1:2]] = b;
      end
    end
    rv_pkg::OP_BRANCH: begin
      if ((word[14:12] == 3'b000 && a == b) || (word[14:12] == 3'b001 && a != b)) begin
        o.next_pc = ref_pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      end
    end
    rv_pkg::OP_LUI: begin
      wr  = 1'b1;
      res = {word[31:12], 12'b0};
    end
    rv_pkg::OP_AUIPC: begin
      wr  = 1'b1;
      res = ref_pc + {word[31:12], 12'b0};
    end
    default: wr = 1'b0;
  endcase
  if (wr && ins.r.rd != 5'd0) ref_regs[ins.r.rd] = res;
  // pc wraps inside the instruction memory
  o.next_pc = o.next_pc & PC_MASK;
  ref_pc    = o.next_pc;
  return o;
endfunction

`endif

/* sim/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

  localparam int            ADDR_W  = rv_pkg::ADDR_W_DEF;
  localparam int            DEPTH   = 1 << ADDR_W;
  localparam rv_pkg::word_t PC_MASK = (32'd1 << (ADDR_W + 2)) - 32'd1;
  // addi x0, x0, 0
  localparam rv_pkg::word_t NOP     = 32'h0000_0013;

  logic              CLK;
  logic              RESET_N;
  logic [ADDR_W-1:0] iaddr;
  logic [ADDR_W-1:0] daddr;
  rv_pkg::word_t     idata;
  rv_pkg::word_t     ddata_r;
  rv_pkg::word_t     ddata_w;
  logic              d_we;
  rv_pkg::word_t     rom [DEPTH];
  rv_pkg::word_t     ram [DEPTH];
  logic              running;
  int                fill_at;

  `include "tb_ref.svh"

  ref_out_t exp_out;

  rv_core #(.ADDR_W(ADDR_W)) dut_i (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .idata   (idata),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .ddata_r (ddata_r),
    .ddata_w (ddata_w),
    .d_we    (d_we)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // both memories answer in the same cycle
  assign idata   = rom[iaddr];
  assign ddata_r = ram[daddr];

  // odd multiplier, every address gets its own word
  function automatic rv_pkg::word_t fill_word(input int a);
    return (rv_pkg::word_t'(a) * 32'h9E37_79B1) ^ 32'hC3A5_0000;
  endfunction

  // ram reloads its fill pattern while in reset
  always @(posedge CLK) begin
    if (!RESET_N) begin
      for (int a = 0; a < DEPTH; a++) ram[a] <= fill_word(a);
    end else if (d_we) begin
      ram[daddr] <= ddata_w;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "first mismatch");
  endtask

  task automatic check_fetch(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
    if (got !== exp) report_mismatch($sformatf("fetch at %0d, expected %0d", got, exp));
  endtask

  task automatic check_store(input logic exp_we, input logic [ADDR_W-1:0] exp_addr,
                             input rv_pkg::word_t exp_data);
    if (d_we !== exp_we) begin
      report_mismatch($sformatf("d_we %b, expected %b", d_we, exp_we));
    end else if (exp_we && (daddr !== exp_addr || ddata_w !== exp_data)) begin
      report_mismatch($sformatf("store [%0d]=%h, expected [%0d]=%h",
                                daddr, ddata_w, exp_addr, exp_data));
    end
  endtask

  task automatic check_word(input int a, input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) report_mismatch($sformatf("ram[%0d] %h, expected %h", a, got, exp));
  endtask

  // mid cycle, dut fetch and store against one model step
  always @(negedge CLK) begin
    if (running) begin
      check_fetch(iaddr, ref_pc[ADDR_W+1:2]);
      exp_out = ref_step(rom[ref_pc[ADDR_W+1:2]]);
      check_store(exp_out.st, exp_out.st_addr, exp_out.st_data);
    end
  end

  task automatic emit(input rv_pkg::word_t w);
    rom[fill_at] = w;
    fill_at++;
  endtask

  // reset on, rom back to no-ops
  task automatic start_program();
    @(posedge CLK);
    #1;
    RESET_N = 1'b0;
    running = 1'b0;
    fill_at = 0;
    for (int a = 0; a < DEPTH; a++) rom[a] = NOP;
  endtask

  task automatic run_program(input string name);
    int cyc;
    int limit;
    limit = 8 + 2 * fill_at + 20;
    cyc   = 0;
    for (int a = 0; a < DEPTH; a++) ref_ram[a] = fill_word(a);
    for (int r = 0; r < 32; r++) ref_regs[r] = '0;
    ref_pc = '0;
    repeat (8) begin
      @(posedge CLK);
      cyc++;
    end
    #1;
    RESET_N = 1'b1;
    running = 1'b1;
    // forward branches only, model pc runs off the end
    while (ref_pc < rv_pkg::word_t'(4 * fill_at)) begin
      @(posedge CLK);
      cyc++;
      if (cyc > limit) begin
        $display("timeout: program %s still running after %0d cycles", name, cyc);
        $display("TEST FAILED");
        $fatal(1, "timeout");
      end
    end
    #1;
    running = 1'b0;
    for (int a = 0; a < DEPTH; a++) check_word(a, ram[a], ref_ram[a]);
    $display("program %s done in %0d cycles", name, cyc);
  endtask

  initial begin
    logic [3:0]  op;
    logic [2:0]  f3;
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [11:0] addrs [4];
    RESET_N = 1'b0;
    running = 1'b0;
    fill_at = 0;
    for (int a = 0; a < DEPTH; a++) rom[a] = NOP;

    // every r-type op, both operand orders
    start_program();
    emit(enc_u(rv_pkg::OP_LUI, 20'h80001, 5'd1));
    emit(enc_i(rv_pkg::OP_IMM, 12'h234, 5'd1, 3'b000, 5'd1));
    emit(enc_i(rv_pkg::OP_IMM, 12'hffb, 5'd0, 3'b000, 5'd2));
    for (int k = 0; k < 32; k++) begin
      op = 4'(k);
      if (!op[3] || op[2:0] == 3'b000 || op[2:0] == 3'b101) begin
        emit(enc_r(op[3] ? 7'h20 : 7'h00, (k >= 16) ? 5'd1 : 5'd2, (k >= 16) ? 5'd2 : 5'd1,
                   op[2:0], 5'd3));
        emit(enc_s(12'(4 * fill_at), 5'd3, 5'd0));
      end
    end
    run_program("alu_reg");

    // i-type, random immediates and shift amounts
    start_program();
    emit(enc_u(rv_pkg::OP_LUI, 20'(rand_bits(20)) | 20'h80000, 5'd1));
    for (int k = 0; k < 24; k++) begin
      f3  = 3'(rand_bits(3));
      imm = 12'(rand_bits(12));
      if (f3 == 3'b001) imm = {7'h00, imm[4:0]};
      if (f3 == 3'b101) imm = {1'b0, imm[11], 5'b0, imm[4:0]};
      emit(enc_i(rv_pkg::OP_IMM, imm, 5'd1, f3, 5'd4));
      emit(enc_s(12'(4 * fill_at), 5'd4, 5'd0));
    end
    run_program("alu_imm");

    // stores to random words, then loads back and copies
    start_program();
    for (int k = 0; k < 4; k++) begin
      emit(enc_u(rv_pkg::OP_LUI, 20'(rand_bits(20)), 5'(5 + k)));
      emit(enc_i(rv_pkg::OP_IMM, 12'(rand_bits(12)), 5'(5 + k), 3'b000, 5'(5 + k)));
      addrs[k] = {1'b0, 9'(rand_bits(9)), 2'b00};
      emit(enc_s(addrs[k], 5'(5 + k), 5'd0));
    end
    for (int k = 0; k < 4; k++) begin
      emit(enc_i(rv_pkg::OP_LOAD, addrs[3 - k], 5'd0, 3'b010, 5'(10 + k)));
      emit(enc_s({1'b0, 9'(rand_bits(9)), 2'b00}, 5'(10 + k), 5'd0));
    end
    run_program("load_store");

    // beq and bne, taken and not taken
    start_program();
    emit(enc_i(rv_pkg::OP_IMM, 12'd5, 5'd0, 3'b000, 5'd1));
    emit(enc_i(rv_pkg::OP_IMM, 12'd5, 5'd0, 3'b000, 5'd2));
    emit(enc_i(rv_pkg::OP_IMM, 12'd7, 5'd0, 3'b000, 5'd3));
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
    emit(enc_s(12'h100, 5'd1, 5'd0));
    emit(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
    emit(enc_s(12'h104, 5'd3, 5'd0));
    emit(enc_b(13'd12, 5'd3, 5'd1, 3'b001));
    emit(enc_s(12'h108, 5'd1, 5'd0));
    emit(enc_s(12'h10c, 5'd2, 5'd0));
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    emit(enc_s(12'h110, 5'd2, 5'd0));
    run_program("branch");

    // auipc at several pcs, then writes to x0
    start_program();
    for (int k = 0; k < 4; k++) begin
      emit(enc_u(rv_pkg::OP_AUIPC, 20'(rand_bits(20)), 5'd6));
      emit(enc_s(12'(4 * fill_at), 5'd6, 5'd0));
      emit(NOP);
    end
    emit(enc_i(rv_pkg::OP_IMM, 12'd123, 5'd0, 3'b000, 5'd0));
    emit(enc_u(rv_pkg::OP_LUI, 20'hABCDE, 5'd0));
    emit(enc_s(12'h200, 5'd0, 5'd0));
    run_program("auipc_x0");

    // random alu, load and store mix
    start_program();
    for (int k = 0; k < 200; k++) begin
      kind = 3'(rand_bits(3));
      f3   = 3'(rand_bits(3));
      rd   = 5'(rand_bits(5));
      rs1  = 5'(rand_bits(5));
      rs2  = 5'(rand_bits(5));
      imm  = 12'(rand_bits(12));
      if (kind < 3'd3) begin
        emit(enc_r(((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'h20 : 7'h00,
                   rs2, rs1, f3, rd));
      end else if (kind < 3'd5) begin
        if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, imm[11], 5'b0, imm[4:0]};
        emit(enc_i(rv_pkg::OP_IMM, imm, rs1, f3, rd));
      end else if (kind == 3'd5) begin
        emit(enc_u(rv_pkg::OP_LUI, 20'(rand_bits(20)), rd));
      end else if (kind == 3'd6) begin
        emit(enc_i(rv_pkg::OP_LOAD, imm, rs1, 3'b010, rd));
      end else begin
        emit(enc_s(imm, rs2, rs1));
      end
    end
    run_program("random");

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter int ADDR_W = rv_pkg::ADDR_W_DEF
) (
  input  logic              CLK,
  input  logic              RESET_N,
  input  rv_pkg::word_t     idata,
  output logic [ADDR_W-1:0] iaddr,
  output logic [ADDR_W-1:0] daddr,
  input  rv_pkg::word_t     ddata_r,
  output rv_pkg::word_t     ddata_w,
  output logic              d_we
);

  rv_pkg::instr_u instr;
  rv_pkg::ctrl_t  ctrl;
  rv_pkg::word_t  imm;
  rv_pkg::word_t  rdata1;
  rv_pkg::word_t  rdata2;
  rv_pkg::word_t  pc;
  rv_pkg::word_t  alu_result;
  rv_pkg::word_t  wb_data;
  logic           alu_zero;

  // fetched word, same cycle
  assign instr = idata;

  decoder decoder_i (
    .instr (instr),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  // register file beside the datapath it feeds
  reg_file reg_file_i (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .rs1     (instr.r.rs1),
    .rs2     (instr.r.rs2),
    .rd      (instr.r.rd),
    .we      (ctrl.reg_we),
    .wdata   (wb_data),
    .rdata1  (rdata1),
    .rdata2  (rdata2)
  );

  execute execute_i (
    .ctrl       (ctrl),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .imm        (imm),
    .pc         (pc),
    .ddata_r    (ddata_r),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .wb_data    (wb_data)
  );

  pc_unit #(
    .ADDR_W (ADDR_W)
  ) pc_unit_i (
    .CLK       (CLK),
    .RESET_N   (RESET_N),
    .branch_eq (ctrl.branch_eq),
    .branch_ne (ctrl.branch_ne),
    .alu_zero  (alu_zero),
    .imm       (imm),
    .pc        (pc)
  );

  // word addresses drop the byte offset
  assign iaddr   = pc[ADDR_W+1:2];
  assign daddr   = alu_result[ADDR_W+1:2];
  assign ddata_w = rdata2;
  assign d_we    = ctrl.mem_we;

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
  parameter int ADDR_W = 10
) (
  input  logic          CLK,
  input  logic          RESET_N,
  input  logic          branch_eq,
  input  logic          branch_ne,
  input  logic          alu_zero,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t pc
);

  // byte address span of the instruction memory
  localparam int PC_W = ADDR_W + 2;

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_seq;
  logic [PC_W-1:0] pc_br;
  logic            taken;

  // both targets wrap inside the span
  assign pc_seq = pc_q + PC_W'(4);
  assign pc_br  = pc_q + imm[PC_W-1:0];

  // condition chosen by the decoder
  assign taken = (branch_eq && alu_zero) || (branch_ne && !alu_zero);

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc_q <= '0;
    end else begin
      pc_q <= taken ? pc_br : pc_seq;
    end
  end

  // zero extend to a full word
  assign pc = {{(rv_pkg::XLEN-PC_W){1'b0}}, pc_q};

  // decoded branch offsets must keep word alignment
  a_pc_aligned: assert property (@(posedge CLK) disable iff (!RESET_N)
    pc_q[1:0] == 2'b00)
    else $error("pc_unit: misaligned pc %h", pc_q);

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rdata1,
  input  rv_pkg::word_t rdata2,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t ddata_r,
  output rv_pkg::word_t alu_result,
  output logic          alu_zero,
  output rv_pkg::word_t wb_data
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  // operand a is pc for auipc and zero for lui
  always_comb begin
    case (ctrl.opa_sel)
      rv_pkg::OPA_RS1: op_a = rdata1;
      rv_pkg::OPA_PC:  op_a = pc;
      default:         op_a = '0;
    endcase
  end

  assign op_b  = ctrl.opb_imm ? imm : rdata2;
  // shift amount only from low 5 bits
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
      // 1 when a is less
      rv_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      // sign fill from bit 31
      rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv_pkg::ALU_AND:  alu_result = op_a & op_b;
      default:          alu_result = '0;
    endcase
  end

  assign alu_zero = ~|alu_result;

  // write-back source
  assign wb_data = (ctrl.wb_sel == rv_pkg::WB_MEM) ? ddata_r : alu_result;

  // on sub the zero flag means equal operands
  always_comb begin
    assert final (ctrl.alu_op != rv_pkg::ALU_SUB || alu_zero == (op_a == op_b))
      else $error("execute: zero flag disagrees with operand compare");
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                     CLK,
  input  logic                     RESET_N,
  input  logic [rv_pkg::REG_AW-1:0] rs1,
  input  logic [rv_pkg::REG_AW-1:0] rs2,
  input  logic [rv_pkg::REG_AW-1:0] rd,
  input  logic                     we,
  input  rv_pkg::word_t            wdata,
  output rv_pkg::word_t            rdata1,
  output rv_pkg::word_t            rdata2
);

  // storage for x1 to x31 only
  rv_pkg::word_t regs [1:31];

  function automatic rv_pkg::word_t read_reg(input logic [rv_pkg::REG_AW-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  assign rdata1 = read_reg(rs1);
  assign rdata2 = read_reg(rs2);

  // write lands by the next cycle
  a_write_then_read: assert property (@(posedge CLK) disable iff (!RESET_N)
    (we && rd != '0) |=> regs[$past(rd)] == $past(wdata))
    else $error("reg_file: x%0d lost its write", $past(rd));

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::instr_u instr,
  output rv_pkg::ctrl_t  ctrl,
  output rv_pkg::word_t  imm
);

  // alt selects sub / sra
  function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::F3_ADD:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
      default:         op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  logic [2:0] f3;
  logic       bit30;

  assign f3    = instr.r.funct3;
  assign bit30 = instr.r.funct7[5];

  // control decode
  always_comb begin
    ctrl = '0;
    case (instr.r.opcode)
      rv_pkg::OP_REG: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = alu_from_f3(f3, bit30);
      end
      rv_pkg::OP_IMM: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opb_imm = 1'b1;
        // bit 30 is immediate data except on right shifts
        ctrl.alu_op  = alu_from_f3(f3, bit30 && (f3 == rv_pkg::F3_SR));
      end
      rv_pkg::OP_LOAD: begin
        if (f3 == rv_pkg::F3_LW) begin
          ctrl.reg_we  = 1'b1;
          ctrl.wb_sel  = rv_pkg::WB_MEM;
          ctrl.opb_imm = 1'b1;
        end
      end
      rv_pkg::OP_STORE: begin
        if (f3 == rv_pkg::F3_SW) begin
          ctrl.mem_we  = 1'b1;
          ctrl.opb_imm = 1'b1;
        end
      end
      rv_pkg::OP_BRANCH: begin
        // compare by subtraction, zero flag decides
        ctrl.alu_op    = rv_pkg::ALU_SUB;
        ctrl.branch_eq = (f3 == rv_pkg::F3_BEQ);
        ctrl.branch_ne = (f3 == rv_pkg::F3_BNE);
      end
      rv_pkg::OP_LUI: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opa_sel = rv_pkg::OPA_ZERO;
        ctrl.opb_imm = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opa_sel = rv_pkg::OPA_PC;
        ctrl.opb_imm = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  // immediate per format, sign from bit 31
  always_comb begin
    case (instr.r.opcode)
      rv_pkg::OP_IMM,
      rv_pkg::OP_LOAD:   imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
      rv_pkg::OP_STORE:  imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
      rv_pkg::OP_BRANCH: imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                                instr.b.imm4_1, 1'b0};
      rv_pkg::OP_LUI,
      rv_pkg::OP_AUIPC:  imm = {instr.u.imm31_12, 12'b0};
      default:           imm = '0;
    endcase
  end

  // one side effect per instruction, and one branch kind at most
  always_comb begin
    assert (!(ctrl.reg_we && ctrl.mem_we) && !(ctrl.branch_eq && ctrl.branch_ne))
      else $error("decoder: conflicting control for opcode %b", instr.r.opcode);
  end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  // datapath word and register index widths
  localparam int XLEN = 32;
  localparam int REG_AW = 5;

  // default memory word address width, top level may override
  localparam int ADDR_W_DEF = 10;

  // funct3 codes of the kept instructions
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  typedef logic [XLEN-1:0] word_t;

  // kept major opcodes
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } opa_sel_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_e;

  // per-format views of one instruction word, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } instr_u;

  // decoded control, all zero is a no-op
  typedef struct packed {
    logic     reg_we;
    logic     mem_we;
    wb_sel_e  wb_sel;
    opa_sel_e opa_sel;
    logic     opb_imm;
    logic     branch_eq;
    logic     branch_ne;
    alu_op_e  alu_op;
  } ctrl_t;

endpackage
